// ==== Bender.yml ====
package:
  name: mips_processor

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/mipsPkg.sv
      - verilog/controlUnit.sv
      - verilog/registerFile.sv
      - verilog/alu.sv
      - verilog/programMemory.sv
      - verilog/dataMemory.sv
      - verilog/fetchUnit.sv
      - verilog/mipsProcessor.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mipsTb.sv

// ==== dv/mipsRefModel.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS subset reference model
// Instruction-level state and execution for the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// Architectural state of the model
word modelPc;
word modelRegs [32];
word modelRam [`DATA_MEM_DEPTH];
word modelPort;
// Copy of the program loaded into the DUT ROM
word modelRom [`PROG_MEM_DEPTH];

task automatic resetModel();
	modelPc = `TEXT_BASE;
	modelPort = '0;
	for (int i = 0; i < 32; i++) begin
		modelRegs[i] = '0;
	end
	for (int i = 0; i < `DATA_MEM_DEPTH; i++) begin
		modelRam[i] = '0;
	end
endtask

// Word slot of the PC, wrapping over the ROM
function automatic int romIndex(word pc);
	word offset;
	offset = pc - `TEXT_BASE;
	return (offset >> 2) % `PROG_MEM_DEPTH;
endfunction

function automatic int ramIndex(word address);
	return (address >> 2) % `DATA_MEM_DEPTH;
endfunction

// Executes one instruction and reports what the DUT should show during it
task automatic stepModel(input logic [7:0] portValue, output word expPc,
		output word expAlu, output bit aluValid);
	word instr;
	word rsVal;
	word rtVal;
	word immSext;
	word pcPlus4;
	word nextPc;
	word result;
	word writeValue;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] shamt;
	logic [4:0] dest;
	bit writes;

	instr = modelRom[romIndex(modelPc)];
	op = instr[31:26];
	fn = instr[5:0];
	shamt = instr[10:6];
	rsVal = modelRegs[instr[25:21]];
	rtVal = modelRegs[instr[20:16]];
	immSext = {{16{instr[15]}}, instr[15:0]};
	pcPlus4 = modelPc + 32'd4;
	nextPc = pcPlus4;
	result = '0;
	writeValue = '0;
	dest = instr[15:11];
	writes = 1'b0;
	aluValid = 1'b0;
	case (op)
		`OP_RTYPE: begin
			aluValid = 1'b1;
			writes = 1'b1;
			case (fn)
				`FN_ADD: result = rsVal + rtVal;
				`FN_SUB: result = rsVal - rtVal;
				`FN_AND: result = rsVal & rtVal;
				`FN_OR: result = rsVal | rtVal;
				`FN_NOR: result = ~(rsVal | rtVal);
				`FN_SLT: result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
				`FN_SLL: result = rtVal << shamt;
				`FN_SRL: result = rtVal >> shamt;
				`FN_JR: begin
					nextPc = rsVal;
					aluValid = 1'b0;
					writes = 1'b0;
				end
				// Unknown funct is a no-op
				default: begin
					aluValid = 1'b0;
					writes = 1'b0;
				end
			endcase
			writeValue = result;
		end
		`OP_ADDI: begin
			result = rsVal + immSext;
			writeValue = result;
			dest = instr[20:16];
			writes = 1'b1;
			aluValid = 1'b1;
		end
		`OP_ORI: begin
			result = rsVal | {16'b0, instr[15:0]};
			writeValue = result;
			dest = instr[20:16];
			writes = 1'b1;
			aluValid = 1'b1;
		end
		`OP_LW: begin
			result = rsVal + immSext;
			aluValid = 1'b1;
			dest = instr[20:16];
			writes = 1'b1;
			// I/O location returns the input port
			if (result == `IO_PORT_ADDR) begin
				writeValue = {24'b0, portValue};
			end else begin
				writeValue = modelRam[ramIndex(result)];
			end
		end
		`OP_SW: begin
			result = rsVal + immSext;
			aluValid = 1'b1;
			if (result == `IO_PORT_ADDR) begin
				modelPort = rtVal;
			end else begin
				modelRam[ramIndex(result)] = rtVal;
			end
		end
		`OP_BEQ: begin
			if (rsVal == rtVal) begin
				nextPc = pcPlus4 + (immSext << 2);
			end
		end
		`OP_BNE: begin
			if (rsVal != rtVal) begin
				nextPc = pcPlus4 + (immSext << 2);
			end
		end
		`OP_J: nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
		`OP_JAL: begin
			nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
			writeValue = pcPlus4;
			dest = 5'd31;
			writes = 1'b1;
		end
		default: ;
	endcase
	// Register 0 stays zero
	if (writes && (dest != 5'd0)) begin
		modelRegs[dest] = writeValue;
	end
	expPc = modelPc;
	expAlu = result;
	modelPc = nextPc;
endtask

`endif

// ==== dv/mipsTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS processor testbench
// Random program run in lockstep with a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsSettings.svh"

module mipsTb;

	import mipsPkg::*;

	localparam int ClkPeriod = 8;
	localparam int NumInstr = 2000;
	// Reset plus program plus some margin
	localparam int TimeoutCycles = NumInstr + 100;

	logic clk;
	logic rstN;
	logic [7:0] portIn;
	word pcOut;
	word aluResultOut;
	word portOut;
	integer seed;

	`include "mipsRefModel.svh"

	mipsProcessor uut (
		.clk(clk),
		.rstN(rstN),
		.portIn(portIn),
		.pcOut(pcOut),
		.aluResultOut(aluResultOut),
		.portOut(portOut)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	task automatic reportMismatch(input string signalName, input word expected,
			input word actual);
		$display("Fail %s expected 0x%h actual 0x%h at %0t", signalName, expected, actual,
			$time);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	function automatic int unsigned randBelow(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Registers 0 to 7 plus $ra
	function automatic logic [4:0] pickReg();
		int unsigned r;
		r = randBelow(9);
		return (r == 8) ? 5'd31 : r[4:0];
	endfunction

	// Word offsets from $0 that sometimes alias one RAM word or hit the port
	function automatic logic [15:0] memOffset();
		if (randBelow(4) == 0) begin
			return 16'hFFFC;
		end
		return 16'(4 * randBelow(16) + 1024 * randBelow(4));
	endfunction

	function automatic logic [25:0] textJumpIndex();
		return 26'((`TEXT_BASE >> 2) + randBelow(`PROG_MEM_DEPTH));
	endfunction

	function automatic word randomInstr();
		logic [5:0] badOps [8];
		logic [5:0] badFuncts [8];
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;

		badOps = '{6'h01, 6'h06, 6'h07, 6'h0A, 6'h0C, 6'h0F, 6'h20, 6'h3F};
		badFuncts = '{6'h01, 6'h03, 6'h09, 6'h18, 6'h21, 6'h23, 6'h26, 6'h2B};
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		// About one slot in twenty is illegal
		if (randBelow(20) == 0) begin
			if (randBelow(2) == 0) begin
				return {badOps[randBelow(8)], 26'($random(seed))};
			end
			return {`OP_RTYPE, rs, rt, rd, 5'd0, badFuncts[randBelow(8)]};
		end
		case (randBelow(17))
			0: return {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_ADD};
			1: return {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SUB};
			2: return {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_AND};
			3: return {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_OR};
			4: return {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_NOR};
			5: return {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SLT};
			6: return {`OP_RTYPE, 5'd0, rt, rd, 5'(randBelow(32)), `FN_SLL};
			7: return {`OP_RTYPE, 5'd0, rt, rd, 5'(randBelow(32)), `FN_SRL};
			// Return through $ra
			8: return {`OP_RTYPE, 5'd31, 15'd0, `FN_JR};
			9: return {`OP_ADDI, rs, rt, 16'($random(seed))};
			10: return {`OP_ORI, rs, rt, 16'($random(seed))};
			11: return {`OP_LW, 5'd0, rt, memOffset()};
			12: return {`OP_SW, 5'd0, rt, memOffset()};
			// Forward branches only so the program keeps moving
			13: return {`OP_BEQ, rs, rt, 16'(randBelow(8))};
			14: return {`OP_BNE, rs, rt, 16'(randBelow(8))};
			15: return {`OP_J, textJumpIndex()};
			default: return {`OP_JAL, textJumpIndex()};
		endcase
	endfunction

	// Watchdog
	initial begin
		#(TimeoutCycles * ClkPeriod);
		$display("Timeout: the run did not finish within %0d clock periods", TimeoutCycles);
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		word expPc;
		word expAlu;
		bit aluValid;
		word instr;

		seed = 32'h591a;
		clk = 1'b0;
		rstN = 1'b0;
		portIn = 8'd0;
		resetModel();

		// Program load while reset is held
		@(posedge clk);
		for (int i = 0; i < `PROG_MEM_DEPTH; i++) begin
			instr = randomInstr();
			uut.progMem.rom[i] = instr;
			modelRom[i] = instr;
		end
		repeat (7) @(posedge clk);
		#1;
		assert (pcOut == `TEXT_BASE) else reportMismatch("pcOut", `TEXT_BASE, pcOut);
		assert (portOut == 32'd0) else reportMismatch("portOut", 32'd0, portOut);
		rstN = 1'b1;

		for (int n = 0; n < NumInstr; n++) begin
			// Combinational outputs have settled by mid-cycle
			@(negedge clk);
			stepModel(portIn, expPc, expAlu, aluValid);
			assert (pcOut == expPc) else reportMismatch("pcOut", expPc, pcOut);
			if (aluValid) begin
				assert (aluResultOut == expAlu)
				else reportMismatch("aluResultOut", expAlu, aluResultOut);
			end
			@(posedge clk);
			#1;
			assert (portOut == modelPort) else reportMismatch("portOut", modelPort, portOut);
			portIn = 8'($random(seed));
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
+incdir+dv
verilog/mipsPkg.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/programMemory.sv
verilog/dataMemory.sv
verilog/fetchUnit.sv
verilog/mipsProcessor.sv
dv/mipsTb.sv

// ==== verilog/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU
// Arithmetic, logic, signed compare and shifts,
// plus the equality flag for branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsSettings.svh"

module alu (
	input mipsPkg::aluCtrl aluOperation,
	input mipsPkg::word a,
	input mipsPkg::word b,
	output mipsPkg::word result,
	output logic zero
);

	import mipsPkg::*;

	word difference;

	assign difference = a - b;

	// Branch compare does not depend on the selected operation
	assign zero = (difference == '0);

	always_comb begin
		case (aluOperation)
			`ALU_ADD: result = a + b;
			`ALU_SUB: result = difference;
			`ALU_AND: result = a & b;
			`ALU_OR: result = a | b;
			`ALU_NOR: result = ~(a | b);
			// Signed compare
			`ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			// Shift b by a[4:0], a is shamt for sll and srl
			`ALU_SLL: result = b << a[4:0];
			`ALU_SRL: result = b >> a[4:0];
			default: result = '0;
		endcase
	end

endmodule

// ==== verilog/controlUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control unit
// Decodes opcode and funct into datapath controls
// and the ALU operation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsSettings.svh"

module controlUnit (
	input mipsPkg::opcodeField opcode,
	input mipsPkg::functField funct,
	output logic regDst,
	output logic aluSrc,
	output logic zeroExtImm,
	output logic shiftOp,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg,
	output logic branchEq,
	output logic branchNe,
	output logic jump,
	output logic jumpReg,
	output logic link,
	output mipsPkg::aluCtrl aluOperation
);

	always_comb begin
		// Everything idle unless the opcode says otherwise
		regDst = 1'b0;
		aluSrc = 1'b0;
		zeroExtImm = 1'b0;
		shiftOp = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		link = 1'b0;
		aluOperation = `ALU_ADD;
		case (opcode)
			`OP_RTYPE: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					`FN_ADD: aluOperation = `ALU_ADD;
					`FN_SUB: aluOperation = `ALU_SUB;
					`FN_AND: aluOperation = `ALU_AND;
					`FN_OR: aluOperation = `ALU_OR;
					`FN_NOR: aluOperation = `ALU_NOR;
					`FN_SLT: aluOperation = `ALU_SLT;
					// Shift amount comes from shamt, not rs
					`FN_SLL: begin
						aluOperation = `ALU_SLL;
						shiftOp = 1'b1;
					end
					`FN_SRL: begin
						aluOperation = `ALU_SRL;
						shiftOp = 1'b1;
					end
					`FN_JR: begin
						regWrite = 1'b0;
						jumpReg = 1'b1;
					end
					// Unknown funct, nothing written
					default: regWrite = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
			end
			`OP_ORI: begin
				aluSrc = 1'b1;
				zeroExtImm = 1'b1;
				regWrite = 1'b1;
				aluOperation = `ALU_OR;
			end
			// Address is rs plus sign-extended offset
			`OP_LW: begin
				aluSrc = 1'b1;
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			`OP_SW: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			`OP_BEQ: begin
				branchEq = 1'b1;
				aluOperation = `ALU_SUB;
			end
			`OP_BNE: begin
				branchNe = 1'b1;
				aluOperation = `ALU_SUB;
			end
			`OP_J: jump = 1'b1;
			// Link register choice is made in the top level
			`OP_JAL: begin
				jump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== verilog/dataMemory.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory
// Word RAM with one memory-mapped I/O port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsSettings.svh"

module dataMemory (
	input logic clk,
	input logic rstN,
	input logic memWrite,
	input mipsPkg::word address,
	input mipsPkg::word writeData,
	input logic [7:0] portIn,
	output mipsPkg::word readData,
	output mipsPkg::word portOut
);

	import mipsPkg::*;

	localparam int IndexWidth = $clog2(`DATA_MEM_DEPTH);

	word ram [`DATA_MEM_DEPTH];
	logic isIo;
	logic [IndexWidth-1:0] index;

	assign isIo = (address == `IO_PORT_ADDR);
	// Word index, upper address bits ignored
	assign index = address[IndexWidth+1:2];

	// Stores go to the port register or to RAM, never both
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			portOut <= '0;
			for (int i = 0; i < `DATA_MEM_DEPTH; i++) begin
				ram[i] <= '0;
			end
		end else if (memWrite) begin
			if (isIo) begin
				portOut <= writeData;
			end else begin
				ram[index] <= writeData;
			end
		end
	end

	// Port input reads back zero-extended
	assign readData = isIo ? {24'b0, portIn} : ram[index];

endmodule

// ==== verilog/fetchUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit
// PC register and next-PC selection for
// branches, jumps and jr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsSettings.svh"

module fetchUnit (
	input logic clk,
	input logic rstN,
	input logic zero,
	input logic branchEq,
	input logic branchNe,
	input logic jump,
	input logic jumpReg,
	input mipsPkg::word immExt,
	input mipsPkg::word regTarget,
	input logic [25:0] jumpIndex,
	output mipsPkg::word pc,
	output mipsPkg::word pcPlus4
);

	import mipsPkg::*;

	word branchTarget;
	word jumpTarget;
	word nextPc;
	logic branchTaken;

	assign pcPlus4 = pc + 32'd4;

	// Offset counts words from the following instruction
	assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
	// Pseudo-direct, stays in the current 256 MB region
	assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

	assign branchTaken = (branchEq && zero) || (branchNe && !zero);

	// jr first, then j/jal, then taken branch
	always_comb begin
		if (jumpReg) begin
			nextPc = regTarget;
		end else if (jump) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `TEXT_BASE;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// ==== verilog/mipsPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS subset types
// Widths shared by the datapath and control blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsPkg;

	// Data word, also used for byte addresses and the PC
	typedef logic [31:0] word;

	// Index into the 32-entry register file
	typedef logic [4:0] regAddr;

	// Instruction bits 31:26
	typedef logic [5:0] opcodeField;

	// Instruction bits 5:0, R-type only
	typedef logic [5:0] functField;

	// Operation select for the ALU, one of the ALU_ codes
	typedef logic [3:0] aluCtrl;

endpackage

// ==== verilog/mipsProcessor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS processor top level
// Single-cycle datapath for a 32-bit MIPS subset,
// one instruction retired per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mipsProcessor (
	input logic clk,
	input logic rstN,
	input logic [7:0] portIn,
	output mipsPkg::word pcOut,
	output mipsPkg::word aluResultOut,
	output mipsPkg::word portOut
);

	import mipsPkg::*;

	// Fetch and instruction fields
	word pc;
	word pcPlus4;
	word instr;
	opcodeField opcode;
	functField funct;
	regAddr rs;
	regAddr rt;
	regAddr rd;
	logic [4:0] shamt;
	logic [15:0] imm;
	logic [25:0] jumpIndex;

	// Control
	logic regDst;
	logic aluSrc;
	logic zeroExtImm;
	logic shiftOp;
	logic regWrite;
	logic memWrite;
	logic memToReg;
	logic branchEq;
	logic branchNe;
	logic jump;
	logic jumpReg;
	logic link;
	aluCtrl aluOperation;

	// Datapath
	regAddr writeRegister;
	word writeData;
	word readData1;
	word readData2;
	word immSext;
	word immZext;
	word aluA;
	word aluB;
	word aluResult;
	word memReadData;
	logic zero;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];
	assign imm = instr[15:0];
	assign jumpIndex = instr[25:0];

	assign immSext = {{16{imm[15]}}, imm};
	// Only ori uses the zero-extended form
	assign immZext = {16'b0, imm};

	// jal always links into $ra
	assign writeRegister = link ? 5'd31 : (regDst ? rd : rt);
	assign writeData = link ? pcPlus4 : (memToReg ? memReadData : aluResult);

	// Operand selection
	assign aluA = shiftOp ? {27'b0, shamt} : readData1;
	assign aluB = aluSrc ? (zeroExtImm ? immZext : immSext) : readData2;

	fetchUnit fetch (
		.clk(clk),
		.rstN(rstN),
		.zero(zero),
		.branchEq(branchEq),
		.branchNe(branchNe),
		.jump(jump),
		.jumpReg(jumpReg),
		.immExt(immSext),
		.regTarget(readData1),
		.jumpIndex(jumpIndex),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	programMemory progMem (
		.pc(pc),
		.instr(instr)
	);

	controlUnit control (
		.opcode(opcode),
		.funct(funct),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.zeroExtImm(zeroExtImm),
		.shiftOp(shiftOp),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.branchEq(branchEq),
		.branchNe(branchNe),
		.jump(jump),
		.jumpReg(jumpReg),
		.link(link),
		.aluOperation(aluOperation)
	);

	registerFile regFile (
		.clk(clk),
		.rstN(rstN),
		.regWrite(regWrite),
		.readRegister1(rs),
		.readRegister2(rt),
		.writeRegister(writeRegister),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu aluUnit (
		.aluOperation(aluOperation),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.zero(zero)
	);

	// ALU result is the byte address, rt is the store data
	dataMemory dataMem (
		.clk(clk),
		.rstN(rstN),
		.memWrite(memWrite),
		.address(aluResult),
		.writeData(readData2),
		.portIn(portIn),
		.readData(memReadData),
		.portOut(portOut)
	);

	assign pcOut = pc;
	assign aluResultOut = aluResult;

endmodule

// ==== verilog/mipsSettings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS subset settings
// Memory sizes, address map and instruction encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Memory depths in words
`define PROG_MEM_DEPTH 64
`define DATA_MEM_DEPTH 256

// Address map
`define TEXT_BASE 32'h0040_0000
`define IO_PORT_ADDR 32'hFFFF_FFFC

// Opcodes
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDI 6'h08
`define OP_ORI 6'h0D
`define OP_LW 6'h23
`define OP_SW 6'h2B

// Funct codes of R-type
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_JR 6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_NOR 6'h27
`define FN_SLT 6'h2A

// ALU operation codes
`define ALU_AND 4'b0000
`define ALU_OR 4'b0001
`define ALU_ADD 4'b0010
`define ALU_SUB 4'b0110
`define ALU_SLT 4'b0111
`define ALU_SLL 4'b1000
`define ALU_SRL 4'b1001
`define ALU_NOR 4'b1100

`endif

// ==== verilog/programMemory.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program memory
// Combinational instruction ROM at the text base
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsSettings.svh"

module programMemory (
	input mipsPkg::word pc,
	output mipsPkg::word instr
);

	import mipsPkg::*;

	localparam int IndexWidth = $clog2(`PROG_MEM_DEPTH);

	// Contents loaded by the testbench during reset
	word rom [`PROG_MEM_DEPTH];
	word offset;

	initial begin
		for (int i = 0; i < `PROG_MEM_DEPTH; i++) begin
			rom[i] = '0;
		end
	end

	// Byte offset from text base, word index wraps at the depth
	assign offset = pc - `TEXT_BASE;
	assign instr = rom[offset[IndexWidth+1:2]];

endmodule

// ==== verilog/registerFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// 32 x 32-bit, two async reads, one clocked write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic rstN,
	input logic regWrite,
	input mipsPkg::regAddr readRegister1,
	input mipsPkg::regAddr readRegister2,
	input mipsPkg::regAddr writeRegister,
	input mipsPkg::word writeData,
	output mipsPkg::word readData1,
	output mipsPkg::word readData2
);

	import mipsPkg::*;

	word registers [32];

	// Register 0 is never written, so it stays zero after reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (regWrite && (writeRegister != 5'd0)) begin
			registers[writeRegister] <= writeData;
		end
	end

	// Reads see the value before this cycle's write
	assign readData1 = registers[readRegister1];
	assign readData2 = registers[readRegister2];

endmodule
